/* src/regfile_consts.svh */
`ifndef REGFILE_CONSTS_SVH
`define REGFILE_CONSTS_SVH

// register file geometry
`define REGF_NUM_REGS 32

// bits needed to name one register
`define REGF_ADDR_W 5

// one scrub cycle for every register including r0
`define REGF_SCRUB_LEN `REGF_NUM_REGS

`endif

/* src/regfilePkg.sv */
`include "regfile_consts.svh"

package regfilePkg;

   // one data word of the core
   typedef logic [31:0] regWordT;

   // register number
   typedef logic [`REGF_ADDR_W-1:0] regAddrT;

   // write-back source where WB_NONE means no write
   typedef enum logic [1:0] {
      WB_RESULT = 2'd0,
      WB_LINK   = 2'd1,
      WB_LOAD   = 2'd2,
      WB_NONE   = 2'd3
   } wbSrcT;

   // byte lanes of a load, one bit per lane
   typedef logic [3:0] byteSelT;

   // store access size
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2,
      SIZE_BAD  = 2'd3
   } accSizeT;

endpackage

/* src/regBankRam.sv */
`timescale 1ns/1ps
`include "regfile_consts.svh"

module regBankRam (
   input  logic                gclk,
   input  logic                we,
   input  regfilePkg::regAddrT wAddr,
   input  regfilePkg::regWordT wData,
   input  logic                re,
   input  regfilePkg::regAddrT rAddr,
   output regfilePkg::regWordT rData
);
   import regfilePkg::*;

   // one word per register
   regWordT mem [0:`REGF_NUM_REGS-1];

   // single write port
   always_ff @(posedge gclk) begin
      if (we) begin
         mem[wAddr] <= wData;
      end
   end

   // synchronous read returns the old word on a same-edge write
   always_ff @(posedge gclk) begin
      if (re) begin
         rData <= mem[rAddr];
      end
   end

endmodule

/* src/regScrubCounter.sv */
`timescale 1ns/1ps
`include "regfile_consts.svh"

module regScrubCounter (
   input  logic                gclk,
   input  logic                rstN,
   output logic                busy,
   output regfilePkg::regAddrT scrubAddr
);
   // one extra bit so the count can sit past the last address
   localparam int cntW = `REGF_ADDR_W + 1;
   localparam logic [cntW-1:0] scrubEnd = cntW'(`REGF_SCRUB_LEN);

   logic [cntW-1:0] cnt;

   // walks 0..31 once after reset, then parks at scrubEnd
   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         cnt <= '0;
      end else if (busy) begin
         cnt <= cnt + cntW'(1);
      end
   end

   // high from reset until the last register has been written
   assign busy = (cnt < scrubEnd);

   // low bits name the register being cleared
   assign scrubAddr = cnt[cntW-2:0];

endmodule

/* src/loadSizer.sv */
`timescale 1ns/1ps

module loadSizer (
   input  logic                gclk,
   input  regfilePkg::byteSelT loadSel,
   input  regfilePkg::regWordT dcacheIn,
   output regfilePkg::regWordT loadData
);
   import regfilePkg::*;

   regWordT sized;

   // pick the lane, shift it down, zero-extend
   always_comb begin
      case (loadSel)
         // single bytes
         4'h8: sized = {24'd0, dcacheIn[31:24]};
         4'h4: sized = {24'd0, dcacheIn[23:16]};
         4'h2: sized = {24'd0, dcacheIn[15:8]};
         4'h1: sized = {24'd0, dcacheIn[7:0]};
         // halfwords
         4'hC: sized = {16'd0, dcacheIn[31:16]};
         4'h3: sized = {16'd0, dcacheIn[15:0]};
         // full word
         4'hF: sized = dcacheIn;
         // malformed select reads as zero
         default: sized = '0;
      endcase
   end

   // registered toward the write port and the store forward path
   always_ff @(posedge gclk) begin
      loadData <= sized;
   end

endmodule

/* src/storeSizer.sv */
`timescale 1ns/1ps

module storeSizer (
   input  regfilePkg::regWordT regD,
   input  regfilePkg::regWordT loadData,
   input  regfilePkg::regWordT result,
   input  regfilePkg::regAddrT wrAddr,
   input  regfilePkg::regAddrT rdAddr,
   input  regfilePkg::wbSrcT   wbSrc,
   input  logic                writeActive,
   input  regfilePkg::accSizeT accSize,
   output regfilePkg::regWordT dcacheOut
);
   import regfilePkg::*;

   logic    hitD;
   logic    fwdLoad;
   logic    fwdResult;
   regWordT storeOp;

   // store register is being written this very cycle
   assign hitD = writeActive && (wrAddr == rdAddr);

   assign fwdLoad   = hitD && (wbSrc == WB_LOAD);
   assign fwdResult = hitD && (wbSrc == WB_RESULT);

   // newest value of the store register
   always_comb begin
      if (fwdLoad) begin
         storeOp = loadData;
      end else if (fwdResult) begin
         storeOp = result;
      end else begin
         storeOp = regD;
      end
   end

   // copy the operand across every lane it can land in
   always_comb begin
      case (accSize)
         SIZE_BYTE: dcacheOut = {4{storeOp[7:0]}};
         SIZE_HALF: dcacheOut = {2{storeOp[15:0]}};
         SIZE_WORD: dcacheOut = storeOp;
         default:   dcacheOut = '0;
      endcase
   end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
   input  logic                gclk,
   input  logic                rstN,
   input  logic                readEn,
   input  logic                stageEn,
   input  regfilePkg::regAddrT raAddr,
   input  regfilePkg::regAddrT rbAddr,
   input  regfilePkg::regAddrT rdAddr,
   input  regfilePkg::regAddrT wrAddr,
   input  regfilePkg::wbSrcT   wbSrc,
   input  regfilePkg::regWordT result,
   input  logic [31:2]         pcLink,
   input  regfilePkg::byteSelT loadSel,
   input  regfilePkg::accSizeT accSize,
   input  regfilePkg::regWordT dcacheIn,
   output regfilePkg::regWordT regA,
   output regfilePkg::regWordT regB,
   output regfilePkg::regWordT dcacheOut,
   output logic                busy
);
   import regfilePkg::*;

   logic    wrEnD;
   logic    writeActive;
   regWordT wbData;
   regWordT loadData;
   regWordT regD;
   regAddrT scrubAddr;

   // bank write port after the scrub override
   logic    bankWe;
   regAddrT bankAddr;
   regWordT bankData;

   // execute enable lines up with write-back one cycle later
   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         wrEnD <= 1'b0;
      end else begin
         wrEnD <= stageEn;
      end
   end

   // r0 is never written by normal traffic
   assign writeActive = (wrAddr != '0) && (wbSrc != WB_NONE) && wrEnD;

   always_comb begin
      case (wbSrc)
         WB_RESULT: wbData = result;
         WB_LINK:   wbData = {pcLink, 2'b00};
         WB_LOAD:   wbData = loadData;
         default:   wbData = '0;
      endcase
   end

   // scrub owns the write port until every register is zero
   assign bankWe   = busy | writeActive;
   assign bankAddr = busy ? scrubAddr : wrAddr;
   assign bankData = busy ? '0 : wbData;

   regScrubCounter scrub_i (
      .gclk      (gclk),
      .rstN      (rstN),
      .busy      (busy),
      .scrubAddr (scrubAddr)
   );

   // three copies for three read ports with the same writes into each
   regBankRam bankA_i (
      .gclk  (gclk),
      .we    (bankWe),
      .wAddr (bankAddr),
      .wData (bankData),
      .re    (readEn),
      .rAddr (raAddr),
      .rData (regA)
   );

   regBankRam bankB_i (
      .gclk  (gclk),
      .we    (bankWe),
      .wAddr (bankAddr),
      .wData (bankData),
      .re    (readEn),
      .rAddr (rbAddr),
      .rData (regB)
   );

   regBankRam bankD_i (
      .gclk  (gclk),
      .we    (bankWe),
      .wAddr (bankAddr),
      .wData (bankData),
      .re    (readEn),
      .rAddr (rdAddr),
      .rData (regD)
   );

   loadSizer loadSizer_i (
      .gclk     (gclk),
      .loadSel  (loadSel),
      .dcacheIn (dcacheIn),
      .loadData (loadData)
   );

   storeSizer storeSizer_i (
      .regD        (regD),
      .loadData    (loadData),
      .result      (result),
      .wrAddr      (wrAddr),
      .rdAddr      (rdAddr),
      .wbSrc       (wbSrc),
      .writeActive (writeActive),
      .accSize     (accSize),
      .dcacheOut   (dcacheOut)
   );

endmodule

/* tests/regFileTb.sv */
`timescale 1ns/1ps
`include "regfile_consts.svh"

module regFileTb;
   import regfilePkg::*;

   logic    gclk;
   logic    rstN;
   logic    readEn;
   logic    stageEn;
   regAddrT raAddr;
   regAddrT rbAddr;
   regAddrT rdAddr;
   regAddrT wrAddr;
   wbSrcT   wbSrc;
   regWordT result;
   logic [31:2] pcLink;
   byteSelT loadSel;
   accSizeT accSize;
   regWordT dcacheIn;
   regWordT regA;
   regWordT regB;
   regWordT dcacheOut;
   logic    busy;

   // fields of one vector in file order
   // ra rb rd wr src en result pcLink sel size din chk expA expB expOut
   logic [31:0] vec [0:63][0:14];
   string   vecName [0:63];
   int      nVec;
   logic    limitReady;
   regWordT model [0:`REGF_NUM_REGS-1];

   regFile regFile_i (
      .gclk      (gclk),
      .rstN      (rstN),
      .readEn    (readEn),
      .stageEn   (stageEn),
      .raAddr    (raAddr),
      .rbAddr    (rbAddr),
      .rdAddr    (rdAddr),
      .wrAddr    (wrAddr),
      .wbSrc     (wbSrc),
      .result    (result),
      .pcLink    (pcLink),
      .loadSel   (loadSel),
      .accSize   (accSize),
      .dcacheIn  (dcacheIn),
      .regA      (regA),
      .regB      (regB),
      .dcacheOut (dcacheOut),
      .busy      (busy)
   );

   always begin
      #4 gclk = ~gclk;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkWord(input string name, input string what,
                            input regWordT expVal, input regWordT actVal);
      assert (actVal === expVal) else begin
         failRun($sformatf("Mismatch %s %s expected %h actual %h",
                           name, what, expVal, actVal));
      end
   endtask

   // lane pick and zero extension for a load
   function automatic regWordT extractLoadLane(input logic [3:0] sel, input regWordT w);
      case (sel)
         4'h1: return {24'd0, w[7:0]};
         4'h2: return {24'd0, w[15:8]};
         4'h4: return {24'd0, w[23:16]};
         4'h8: return {24'd0, w[31:24]};
         4'h3: return {16'd0, w[15:0]};
         4'hC: return {16'd0, w[31:16]};
         4'hF: return w;
         default: return 32'd0;
      endcase
   endfunction

   function automatic regWordT replicateStore(input logic [1:0] size, input regWordT w);
      if (size == 2'd0) begin
         return {w[7:0], w[7:0], w[7:0], w[7:0]};
      end else if (size == 2'd1) begin
         return {w[15:0], w[15:0]};
      end else if (size == 2'd2) begin
         return w;
      end
      return 32'd0;
   endfunction

   task automatic loadVectors();
      int    fd;
      int    cnt;
      string line;
      string nm;
      logic [31:0] f [0:14];
      fd = $fopen("tests/regfile_vectors.txt", "r");
      if (fd == 0) begin
         failRun("could not open the vector file");
      end
      nVec = 0;
      while ($fgets(line, fd) != 0) begin
         // skip comments and blank lines
         if (line.len() < 2 || line.substr(0, 0) == "#") begin
            continue;
         end
         cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                       f[10], f[11], f[12], f[13], f[14]);
         if (cnt != 16) begin
            failRun($sformatf("vector line %0d has the wrong number of fields", nVec));
         end
         vecName[nVec] = nm;
         for (int k = 0; k < 15; k++) begin
            vec[nVec][k] = f[k];
         end
         nVec++;
      end
      $fclose(fd);
   endtask

   // full reset with the scrub pass and a read-back of every register
   task automatic resetAndScrub(input string name);
      int scrubCycles;
      rstN = 1'b0;
      repeat (16) @(negedge gclk);
      checkWord(name, "busy in reset", 32'd1, {31'd0, busy});
      rstN = 1'b1;
      scrubCycles = 0;
      while (busy) begin
         @(negedge gclk);
         scrubCycles++;
      end
      // one cycle for each register address
      checkWord(name, "busy cycles", `REGF_NUM_REGS, scrubCycles);
      for (int r = 0; r < `REGF_NUM_REGS; r++) begin
         raAddr = regAddrT'(r);
         rbAddr = regAddrT'(`REGF_NUM_REGS - 1 - r);
         readEn = 1'b1;
         @(negedge gclk);
         checkWord(name, "regA", 32'd0, regA);
         checkWord(name, "regB", 32'd0, regB);
         model[r] = '0;
      end
      readEn = 1'b0;
   endtask

   task automatic runVector(input int i);
      logic    active;
      regWordT newVal;
      regWordT storeOp;
      regWordT expOut;
      raAddr   = vec[i][0][4:0];
      rbAddr   = vec[i][1][4:0];
      rdAddr   = vec[i][2][4:0];
      wrAddr   = vec[i][3][4:0];
      wbSrc    = wbSrcT'(vec[i][4][1:0]);
      stageEn  = vec[i][5][0];
      result   = vec[i][6];
      pcLink   = vec[i][7][29:0];
      loadSel  = vec[i][8][3:0];
      accSize  = accSizeT'(vec[i][9][1:0]);
      dcacheIn = vec[i][10];
      readEn   = 1'b1;
      // expected values come from the model before this line writes
      active = vec[i][5][0] && (vec[i][3][4:0] != 5'd0) && (vec[i][4][1:0] != 2'd3);
      case (vec[i][4][1:0])
         2'd0: newVal = vec[i][6];
         2'd1: newVal = {vec[i][7][29:0], 2'b00};
         default: newVal = extractLoadLane(vec[i][8][3:0], vec[i][10]);
      endcase
      storeOp = model[vec[i][2][4:0]];
      if (active && vec[i][3][4:0] == vec[i][2][4:0] && vec[i][4][1:0] != 2'd1) begin
         storeOp = newVal;
      end
      expOut = replicateStore(vec[i][9][1:0], storeOp);
      @(negedge gclk);
      if (vec[i][11][0]) begin
         checkWord(vecName[i], "file regA vs model", model[vec[i][0][4:0]], vec[i][12]);
         checkWord(vecName[i], "file regB vs model", model[vec[i][1][4:0]], vec[i][13]);
         checkWord(vecName[i], "file dcacheOut vs model", expOut, vec[i][14]);
         checkWord(vecName[i], "regA", vec[i][12], regA);
         checkWord(vecName[i], "regB", vec[i][13], regB);
         checkWord(vecName[i], "dcacheOut", vec[i][14], dcacheOut);
      end
      stageEn = 1'b0;
      readEn  = 1'b0;
      // write commits at the next rising edge
      if (active) begin
         model[vec[i][3][4:0]] = newVal;
      end
      @(negedge gclk);
   endtask

   // watchdog allows two cycles per vector and two reset and scrub rounds
   initial begin
      wait (limitReady);
      #((2 * nVec + 192) * 8);
      $display("run timed out before all tests finished");
      $display(">>> FAIL");
      $fatal(1, "timeout");
   end

   initial begin
      gclk = 1'b0;
      rstN = 1'b0;
      readEn = 1'b0;
      stageEn = 1'b0;
      raAddr = '0;
      rbAddr = '0;
      rdAddr = '0;
      wrAddr = '0;
      wbSrc = WB_NONE;
      result = '0;
      pcLink = '0;
      loadSel = '0;
      accSize = SIZE_WORD;
      dcacheIn = '0;
      limitReady = 1'b0;
      loadVectors();
      limitReady = 1'b1;
      resetAndScrub("scrub");
      for (int i = 0; i < nVec; i++) begin
         runVector(i);
      end
      // a second scrub must clear the values the vectors left behind
      resetAndScrub("rescrub");
      $display(">>> PASS");
      $finish;
   end

endmodule

/* tests/regfile_vectors.txt */
# name ra rb rd wr src en result pcLink loadSel accSize dcacheIn chk expA expB expOut
# src 0 result 1 link 2 load 3 none; size 0 byte 1 half 2 word 3 bad; all fields hex
wrRes    01 02 03 01 0 1 8c4f21d7 00000000 0 2 00000000 1 00000000 00000000 00000000
wrLink   01 02 01 02 1 1 00000000 0a3c5e71 0 2 00000000 1 8c4f21d7 00000000 8c4f21d7
wrLoad   02 03 02 03 2 1 00000000 00000000 f 2 d27c5e19 1 28f179c4 00000000 28f179c4
readBack 03 01 03 00 3 0 00000000 00000000 0 2 00000000 1 d27c5e19 8c4f21d7 d27c5e19
wrZero   00 01 00 00 0 1 3e9a06b5 00000000 0 2 00000000 1 00000000 8c4f21d7 00000000
wrNone   00 01 01 01 3 1 3e9a06b5 00000000 0 2 00000000 1 00000000 8c4f21d7 8c4f21d7
chkKeep  00 01 00 00 3 0 00000000 00000000 0 2 00000000 1 00000000 8c4f21d7 00000000
ld1      04 00 00 04 2 1 00000000 00000000 1 2 61b3f08a 1 00000000 00000000 00000000
ld2      04 00 00 04 2 1 00000000 00000000 2 2 61b3f08a 1 0000008a 00000000 00000000
ld4      04 00 00 04 2 1 00000000 00000000 4 2 61b3f08a 1 000000f0 00000000 00000000
ld8      04 00 00 04 2 1 00000000 00000000 8 2 61b3f08a 1 000000b3 00000000 00000000
ld3      04 00 00 04 2 1 00000000 00000000 3 2 61b3f08a 1 00000061 00000000 00000000
ldC      04 00 00 04 2 1 00000000 00000000 c 2 61b3f08a 1 0000f08a 00000000 00000000
ldF      04 00 00 04 2 1 00000000 00000000 f 2 61b3f08a 1 000061b3 00000000 00000000
ldBad    04 00 00 04 2 1 00000000 00000000 6 2 61b3f08a 1 61b3f08a 00000000 00000000
ldChk    04 00 00 00 3 0 00000000 00000000 0 2 00000000 1 00000000 00000000 00000000
stByte   01 02 01 00 3 0 00000000 00000000 0 0 00000000 1 8c4f21d7 28f179c4 d7d7d7d7
stHalf   01 02 01 00 3 0 00000000 00000000 0 1 00000000 1 8c4f21d7 28f179c4 21d721d7
stWord   01 02 01 00 3 0 00000000 00000000 0 2 00000000 1 8c4f21d7 28f179c4 8c4f21d7
stBad    01 02 01 00 3 0 00000000 00000000 0 3 00000000 1 8c4f21d7 28f179c4 00000000
fwdRes   05 01 05 05 0 1 3e9a06b5 00000000 0 2 00000000 1 00000000 8c4f21d7 3e9a06b5
fwdLoad  05 06 06 06 2 1 00000000 00000000 3 0 d27c5e19 1 3e9a06b5 00000000 19191919
fwdLink  06 05 07 07 1 1 00000000 0a3c5e71 0 2 00000000 1 00005e19 3e9a06b5 00000000
fwdNoEn  07 03 03 03 0 0 3e9a06b5 00000000 0 1 00000000 1 28f179c4 d27c5e19 5e195e19
final    06 07 05 00 3 0 00000000 00000000 0 2 00000000 1 00005e19 28f179c4 3e9a06b5
idle     00 00 00 00 3 0 00000000 00000000 0 2 00000000 0 00000000 00000000 00000000

/* vlog.f */
+incdir+src
src/regfilePkg.sv
src/regBankRam.sv
src/regScrubCounter.sv
src/loadSizer.sv
src/storeSizer.sv
src/regFile.sv
tests/regFileTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module regFileTb -o regFileSim

output=$(./obj_dir/regFileSim) || true
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
   exit 0
else
   exit 1
fi
